//--- src/adc_link_pkg.sv
`default_nettype none

package adc_link_pkg;

   // ADC and packed sample widths
   localparam int ADC_W    = 14;
   localparam int SAMPLE_W = 32;   // Channel A high half, channel B low half
   localparam int SER_W    = 16;   // Serdes word

   // Sample FIFO
   localparam int FIFO_DEPTH = 16;
   localparam int CNT_W      = 5;    // Holds 0 to FIFO_DEPTH

   // Framing
   localparam int FRAME_LEN = 8;    // Pairs per frame
   localparam int DECIM_W   = 4;

   // K characters
   localparam logic [7:0]       K_COMMA   = 8'hBC;
   localparam logic [SER_W-1:0] IDLE_WORD = 16'hBCBC;   // Sent with both K flags

   // Framer states
   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_HEADER  = 2'd1;
   localparam logic [1:0] ST_PAYLOAD = 2'd2;

endpackage

`default_nettype wire

//--- src/adc_capture.sv
`default_nettype none
`timescale 1ns/10ps

module adc_capture
  (
   input  logic                               dsp_clk,
   input  logic                               reset_i,
   input  logic                               run_i,
   input  logic [adc_link_pkg::DECIM_W-1:0]   decim_i,
   input  logic [adc_link_pkg::ADC_W-1:0]     adc_a_i,
   input  logic                               adc_ovf_a_i,
   input  logic [adc_link_pkg::ADC_W-1:0]     adc_b_i,
   input  logic                               adc_ovf_b_i,
   input  logic                               full_i,
   output logic                               wr_en_o,
   output logic [adc_link_pkg::SAMPLE_W-1:0]  wr_data_o,
   output logic                               overrun_o
   );

   import adc_link_pkg::*;

   logic [ADC_W-1:0]   adc_a_r1, adc_b_r1, adc_a_r2, adc_b_r2;
   logic               ovf_a_r1, ovf_b_r1, ovf_a_r2, ovf_b_r2;
   logic [DECIM_W-1:0] decim_r1, decim_r2;
   logic               run_r1, run_r2;
   logic               run_prev;         // Run of the previous decided sample
   logic [DECIM_W-1:0] decim_cnt;        // Samples left to skip
   logic               keep;
   logic               keep_q;

   // Two register stages at the pins
   always_ff @(posedge dsp_clk)
   begin
      adc_a_r1 <= adc_a_i;
      adc_b_r1 <= adc_b_i;
      ovf_a_r1 <= adc_ovf_a_i;
      ovf_b_r1 <= adc_ovf_b_i;
      decim_r1 <= decim_i;
      adc_a_r2 <= adc_a_r1;
      adc_b_r2 <= adc_b_r1;
      ovf_a_r2 <= ovf_a_r1;
      ovf_b_r2 <= ovf_b_r1;
      decim_r2 <= decim_r1;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         run_r1 <= 1'b0;
         run_r2 <= 1'b0;
      end
      else
      begin
         run_r1 <= run_i;
         run_r2 <= run_r1;
      end
   end

   // First sample after a rising run, then every (decim+1)th
   assign keep = run_r2 & (~run_prev | (decim_cnt == '0));

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         run_prev  <= 1'b0;
         decim_cnt <= '0;
         keep_q    <= 1'b0;
         overrun_o <= 1'b0;
      end
      else
      begin
         run_prev <= run_r2;
         keep_q   <= keep;
         if (keep)
            decim_cnt <= decim_r2;         // Reload on every kept sample
         else if (run_r2)
            decim_cnt <= decim_cnt - 1'b1;
         if (keep_q && full_i)
            overrun_o <= 1'b1;             // Sticky until reset
      end
   end

   // Overflow in bit 15 of each half, bit 14 stays zero
   always_ff @(posedge dsp_clk)
   begin
      wr_data_o <= {ovf_a_r2, 1'b0, adc_a_r2, ovf_b_r2, 1'b0, adc_b_r2};
   end

   // Full is sampled in the write cycle itself, so a write landing now is counted
   assign wr_en_o = keep_q & ~full_i;

endmodule

`default_nettype wire

//--- src/sample_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module sample_fifo
  (
   input  logic                               dsp_clk,
   input  logic                               reset_i,
   input  logic                               wr_en_i,
   input  logic [adc_link_pkg::SAMPLE_W-1:0]  wr_data_i,
   output logic                               full_o,
   input  logic                               rd_en_i,
   output logic [adc_link_pkg::SAMPLE_W-1:0]  rd_data_o,
   output logic [adc_link_pkg::CNT_W-1:0]     count_o
   );

   import adc_link_pkg::*;

   logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
   logic [CNT_W-2:0]    wr_ptr;   // One bit narrower than the count
   logic [CNT_W-2:0]    rd_ptr;
   logic [CNT_W-1:0]    count;

   // Storage and registered read port
   always_ff @(posedge dsp_clk)
   begin
      if (wr_en_i)
         mem[wr_ptr] <= wr_data_i;
      if (rd_en_i)
         rd_data_o <= mem[rd_ptr];
   end

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en_i)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at FIFO_DEPTH
         if (rd_en_i)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en_i, rd_en_i})
            2'b10:
               count <= count + 1'b1;
            2'b01:
               count <= count - 1'b1;
            default:
               count <= count;     // Both or neither
         endcase
      end
   end

   assign full_o  = (count == CNT_W'(FIFO_DEPTH));
   assign count_o = count;

endmodule

`default_nettype wire

//--- src/serdes_framer.sv
`default_nettype none
`timescale 1ns/10ps

module serdes_framer
  (
   input  logic                               dsp_clk,
   input  logic                               reset_i,
   input  logic [adc_link_pkg::CNT_W-1:0]     count_i,
   output logic                               rd_en_o,
   input  logic [adc_link_pkg::SAMPLE_W-1:0]  rd_data_i,
   output logic [adc_link_pkg::SER_W-1:0]     ser_t_o,
   output logic                               ser_tklsb_o,
   output logic                               ser_tkmsb_o
   );

   import adc_link_pkg::*;

   logic [1:0]                     state;
   logic [$clog2(FRAME_LEN)-1:0]   pair_cnt;
   logic                           half_sel;    // Low half goes out when set
   logic [7:0]                     seq_num;
   logic                           frame_ready;
   logic                           last_pair;

   // A whole frame must sit in the FIFO before the header goes out
   assign frame_ready = (count_i >= CNT_W'(FRAME_LEN));
   assign last_pair   = (pair_cnt == ($clog2(FRAME_LEN))'(FRAME_LEN - 1));

   // Read strobe leads each pair by one cycle, so the data is ready for the high half
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         state       <= ST_IDLE;
         rd_en_o     <= 1'b0;
         pair_cnt    <= '0;
         half_sel    <= 1'b0;
         seq_num     <= '0;
         ser_t_o     <= IDLE_WORD;
         ser_tklsb_o <= 1'b1;
         ser_tkmsb_o <= 1'b1;
      end
      else
      begin
         case (state)
            ST_IDLE:
               begin
                  ser_t_o     <= IDLE_WORD;
                  ser_tklsb_o <= 1'b1;
                  ser_tkmsb_o <= 1'b1;
                  if (frame_ready)
                  begin
                     state   <= ST_HEADER;
                     rd_en_o <= 1'b1;     // Fetch the first pair
                  end
               end

            ST_HEADER:
               begin
                  ser_t_o     <= {seq_num, K_COMMA};
                  ser_tklsb_o <= 1'b1;    // Comma in the low byte only
                  ser_tkmsb_o <= 1'b0;
                  seq_num     <= seq_num + 1'b1;
                  rd_en_o     <= 1'b0;
                  pair_cnt    <= '0;
                  half_sel    <= 1'b0;
                  state       <= ST_PAYLOAD;
               end

            ST_PAYLOAD:
               begin
                  ser_tklsb_o <= 1'b0;
                  ser_tkmsb_o <= 1'b0;
                  if (!half_sel)
                  begin
                     ser_t_o  <= rd_data_i[SAMPLE_W-1:SER_W];   // Channel A
                     half_sel <= 1'b1;
                     rd_en_o  <= ~last_pair;   // Prefetch the next pair
                  end
                  else
                  begin
                     ser_t_o  <= rd_data_i[SER_W-1:0];          // Channel B
                     half_sel <= 1'b0;
                     rd_en_o  <= 1'b0;
                     pair_cnt <= pair_cnt + 1'b1;
                     if (last_pair)
                     begin
                        // Back to back frames skip the idle state
                        if (frame_ready)
                        begin
                           state   <= ST_HEADER;
                           rd_en_o <= 1'b1;
                        end
                        else
                        begin
                           state <= ST_IDLE;
                        end
                     end
                  end
               end

            default:
               begin
                  state   <= ST_IDLE;
                  rd_en_o <= 1'b0;
               end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/adc_serdes_top.sv
`default_nettype none
`timescale 1ns/10ps

module adc_serdes_top
  (
   input  logic                              dsp_clk,
   input  logic                              reset_i,
   input  logic                              run_i,
   input  logic [adc_link_pkg::DECIM_W-1:0]  decim_i,
   input  logic [adc_link_pkg::ADC_W-1:0]    adc_a_i,
   input  logic                              adc_ovf_a_i,
   input  logic [adc_link_pkg::ADC_W-1:0]    adc_b_i,
   input  logic                              adc_ovf_b_i,
   output logic [adc_link_pkg::SER_W-1:0]    ser_t_o,
   output logic                              ser_tklsb_o,
   output logic                              ser_tkmsb_o,
   output logic                              overrun_o
   );

   import adc_link_pkg::*;

   logic                wr_en;
   logic [SAMPLE_W-1:0] wr_data;
   logic                full;
   logic                rd_en;
   logic [SAMPLE_W-1:0] rd_data;
   logic [CNT_W-1:0]    count;

   adc_capture cap0
     (.dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .run_i       (run_i),
      .decim_i     (decim_i),
      .adc_a_i     (adc_a_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .full_i      (full),
      .wr_en_o     (wr_en),
      .wr_data_o   (wr_data),
      .overrun_o   (overrun_o));

   sample_fifo fifo0
     (.dsp_clk   (dsp_clk),
      .reset_i   (reset_i),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .full_o    (full),
      .rd_en_i   (rd_en),
      .rd_data_o (rd_data),
      .count_o   (count));

   serdes_framer frm0
     (.dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .count_i     (count),
      .rd_en_o     (rd_en),
      .rd_data_i   (rd_data),
      .ser_t_o     (ser_t_o),
      .ser_tklsb_o (ser_tklsb_o),
      .ser_tkmsb_o (ser_tkmsb_o));

endmodule

`default_nettype wire

//--- verif/tb_adc_serdes.sv
`default_nettype none
`timescale 1ns/10ps

module tb_adc_serdes;

   import adc_link_pkg::*;

   localparam int FRAME_TIMEOUT = 300;   // Cycles for the slowest decimation plus margin

   logic               dsp_clk = 1'b0;
   logic               reset_i;
   logic               run_i;
   logic [DECIM_W-1:0] decim_i;
   logic [ADC_W-1:0]   adc_a_i;
   logic               adc_ovf_a_i;
   logic [ADC_W-1:0]   adc_b_i;
   logic               adc_ovf_b_i;
   logic [SER_W-1:0]   ser_t_o;
   logic               ser_tklsb_o;
   logic               ser_tkmsb_o;
   logic               overrun_o;

   // Controls set by the main sequence
   logic               run_mode;
   logic [DECIM_W-1:0] decim_mode;
   logic               mon_on;
   logic               expect_idle;    // Any header is an error while set
   logic               lossy;          // Pairs may be missing from frames

   // Model state owned by the monitor
   logic [SAMPLE_W-1:0] exp_q[$];
   logic                prev_run   = 1'b0;
   logic [DECIM_W-1:0]  skip_cnt   = '0;   // Samples left to skip
   int                  kept_total = 0;

   // Parser state
   int                  mon_pos     = 0;   // 0 between frames, else payload word index
   logic [7:0]          exp_seq     = 8'd0;
   int                  frames_seen = 0;
   int                  idle_run    = 0;
   logic                ovr_seen    = 1'b0;
   logic [SER_W-1:0]    high_half   = '0;

   adc_serdes_top dut0
     (.dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .run_i       (run_i),
      .decim_i     (decim_i),
      .adc_a_i     (adc_a_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .ser_t_o     (ser_t_o),
      .ser_tklsb_o (ser_tklsb_o),
      .ser_tkmsb_o (ser_tkmsb_o),
      .overrun_o   (overrun_o));

   always #5 dsp_clk = ~dsp_clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
      begin
         $display("FAILED at time %0d ns: %s is %h, expected %h", $time, name, got, want);
         $display("TEST FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Run aborted");
   endtask

   // Keep the first sample of a run, then one in every decim+1
   task automatic model_sample();
      logic keep;
      keep = run_i && (!prev_run || skip_cnt == '0);
      if (keep)
      begin
         exp_q.push_back({adc_ovf_a_i, 1'b0, adc_a_i, adc_ovf_b_i, 1'b0, adc_b_i});
         kept_total++;
         skip_cnt = decim_i;
      end
      else if (run_i)
         skip_cnt = skip_cnt - 1'b1;
      prev_run = run_i;
   endtask

   task automatic take_pair(input logic [SAMPLE_W-1:0] got);
      logic [SAMPLE_W-1:0] want;
      if (exp_q.size() == 0)
         fail_run("A frame carried a pair although the model had no pair left");
      else
      begin
         // Dropped samples are skipped over when overrun is allowed
         if (lossy)
            while (exp_q.size() > 1 && exp_q[0] != got)
               void'(exp_q.pop_front());
         want = exp_q.pop_front();
         check_value("frame pair", got, want);
      end
   endtask

   task automatic parse_word();
      if (!lossy)
         check_value("overrun_o", 32'(overrun_o), 32'd0);
      if (ovr_seen)
         check_value("overrun_o", 32'(overrun_o), 32'd1);   // Sticky
      if (overrun_o)
         ovr_seen = 1'b1;
      if (mon_pos == 0)
      begin
         if (expect_idle || (ser_tklsb_o && ser_tkmsb_o))
         begin
            check_value("ser_t_o", 32'(ser_t_o), 32'(IDLE_WORD));
            check_value("ser_tklsb_o", 32'(ser_tklsb_o), 32'd1);
            check_value("ser_tkmsb_o", 32'(ser_tkmsb_o), 32'd1);
            idle_run++;
         end
         else
         begin
            check_value("ser_tkmsb_o", 32'(ser_tkmsb_o), 32'd0);
            check_value("ser_tklsb_o", 32'(ser_tklsb_o), 32'd1);
            check_value("ser_t_o", 32'(ser_t_o), 32'({exp_seq, K_COMMA}));
            exp_seq = exp_seq + 8'd1;
            frames_seen++;
            idle_run = 0;
            mon_pos  = 1;
         end
      end
      else
      begin
         check_value("ser_tklsb_o", 32'(ser_tklsb_o), 32'd0);
         check_value("ser_tkmsb_o", 32'(ser_tkmsb_o), 32'd0);
         if (mon_pos % 2 == 1)
            high_half = ser_t_o;            // Channel A first
         else
            take_pair({high_half, ser_t_o});
         mon_pos = (mon_pos == 2 * FRAME_LEN) ? 0 : mon_pos + 1;
      end
   endtask

   // Inputs and outputs are both stable at the falling edge
   always @(negedge dsp_clk)
   begin
      model_sample();
      if (mon_on)
         parse_word();
   end

   // New ADC samples and controls 1 ns after each rising edge
   task automatic drive_inputs();
      run_i       = 1'b0;
      decim_i     = '0;
      adc_a_i     = '0;
      adc_ovf_a_i = 1'b0;
      adc_b_i     = '0;
      adc_ovf_b_i = 1'b0;
      forever
      begin
         @(posedge dsp_clk);
         #1;
         adc_a_i     = ADC_W'($urandom);
         adc_ovf_a_i = 1'($urandom);
         adc_b_i     = ADC_W'($urandom);
         adc_ovf_b_i = 1'($urandom);
         run_i       = run_mode;
         decim_i     = decim_mode;
      end
   endtask

   task automatic wait_frames(input int n);
      int target;
      int cycles;
      for (int i = 0; i < n; i++)
      begin
         target = frames_seen + 1;
         cycles = 0;
         while (frames_seen < target)
         begin
            @(posedge dsp_clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT)
               fail_run("No frame header arrived on the serdes port in time");
         end
      end
   endtask

   task automatic wait_partial();
      int cycles;
      cycles = 0;
      while (kept_total % FRAME_LEN == 0)
      begin
         @(posedge dsp_clk);
         cycles++;
         if (cycles > FRAME_TIMEOUT)
            fail_run("The kept sample count never left a partial frame");
      end
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (mon_pos != 0 || exp_q.size() >= FRAME_LEN)
      begin
         @(posedge dsp_clk);
         cycles++;
         if (cycles > 2 * FRAME_TIMEOUT)
            fail_run("The complete frames were not sent after run_i was dropped");
      end
   endtask

   task automatic wait_overrun();
      int cycles;
      cycles = 0;
      while (!overrun_o)
      begin
         @(posedge dsp_clk);
         cycles++;
         if (cycles > FRAME_TIMEOUT)
            fail_run("overrun_o never rose with a decimation factor of zero");
      end
   endtask

   task automatic wait_quiet();
      int cycles;
      cycles = 0;
      while (idle_run < 40)
      begin
         @(posedge dsp_clk);
         cycles++;
         if (cycles > 8 * FRAME_TIMEOUT)
            fail_run("The serdes port never returned to idle words");
      end
   endtask

   initial
   begin
      void'($urandom(32'hfe37_ed0b));
      reset_i     = 1'b1;
      run_mode    = 1'b0;
      decim_mode  = '0;
      mon_on      = 1'b0;
      expect_idle = 1'b0;
      lossy       = 1'b0;
      fork
         drive_inputs();
      join_none
      repeat (2) @(posedge dsp_clk);
      #1 reset_i = 1'b0;
      mon_on = 1'b1;

      // Idle line with run low
      expect_idle = 1'b1;
      repeat (30) @(posedge dsp_clk);
      expect_idle = 1'b0;

      // 40 frames over random decimation factors
      for (int seg = 0; seg < 5; seg++)
      begin
         @(posedge dsp_clk);
         decim_mode = DECIM_W'(1 + $urandom % 15);
         run_mode   = 1'b1;
         wait_frames(8);
      end

      // Stop with a partial frame left behind
      wait_partial();
      run_mode = 1'b0;
      wait_drained();
      expect_idle = 1'b1;
      repeat (60) @(posedge dsp_clk);
      expect_idle = 1'b0;
      decim_mode  = DECIM_W'(1 + $urandom % 15);
      run_mode    = 1'b1;
      wait_frames(3);

      // Full rate burst overruns the FIFO
      lossy      = 1'b1;
      decim_mode = '0;
      wait_overrun();
      wait_frames(6);
      run_mode = 1'b0;
      wait_quiet();
      check_value("overrun_o", 32'(overrun_o), 32'd1);

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
src/adc_link_pkg.sv
src/adc_capture.sv
src/sample_fifo.sv
src/serdes_framer.sv
src/adc_serdes_top.sv
verif/tb_adc_serdes.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/10ps \
   --top-module tb_adc_serdes -f all.f -o tb_adc_serdes \
   && ./obj_dir/tb_adc_serdes | tee /dev/stderr | grep -q "^TEST PASSED$" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

exit 0
